//--- i2c_macros.svh
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// bus field widths
`define I2C_DEV_ADDR_W 7
`define I2C_REG_ADDR_W 16
`define I2C_BYTE_W 8

// i2c_clk cycles per bus bit
`define I2C_BIT_CYCLES 4

// phase lengths in i2c_clk cycles
// start plus device address byte
`define I2C_DEV_PHASE_LEN 40
// address or data byte with its ack slot
`define I2C_BYTE_PHASE_LEN 36
// repeated start plus device address byte
`define I2C_RESTART_PHASE_LEN 52
`define I2C_STOP_PHASE_LEN 17

`endif

//--- i2c_pkg.sv
`include "i2c_macros.svh"

package i2c_pkg;

  typedef logic [`I2C_DEV_ADDR_W-1:0] dev_addr_t;
  typedef logic [`I2C_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`I2C_BYTE_W-1:0]     byte_t;

  // sized for the longest phase
  typedef logic [$clog2(`I2C_RESTART_PHASE_LEN)-1:0] phase_cnt_t;

  // one state per bus phase
  typedef enum logic [2:0]
  {
    st_idle,
    st_dev_addr,
    st_reg_hi,
    st_reg_lo,
    st_write_data,
    st_restart_addr,
    st_read_data,
    st_stop
  } i2c_state_t;

endpackage

//--- i2c_txn_seq.sv
`include "i2c_macros.svh"

module i2c_txn_seq
(
  input  logic                i2c_clk,
  input  logic                rst_n,
  input  logic                i2c_exec,
  input  logic                addr16,
  input  logic                rd_wr_n,
  input  logic                phase_done,
  input  i2c_pkg::dev_addr_t  dev_addr,
  input  i2c_pkg::reg_addr_t  reg_addr,
  input  i2c_pkg::byte_t      wr_data,
  output i2c_pkg::i2c_state_t state,
  output i2c_pkg::byte_t      tx_byte,
  output logic                i2c_done
);

  i2c_pkg::i2c_state_t next_state;
  i2c_pkg::dev_addr_t  dev_addr_r;
  i2c_pkg::reg_addr_t  reg_addr_r;
  i2c_pkg::byte_t      wr_data_r;
  logic                addr16_r;
  logic                rd_r;
  logic                start_req;

  // exec only counts while idle
  assign start_req = (state == i2c_pkg::st_idle) && i2c_exec;

  always_comb
  begin
    next_state = state;
    case (state)
      i2c_pkg::st_idle:
        if (start_req)
          next_state = i2c_pkg::st_dev_addr;
      i2c_pkg::st_dev_addr:
        if (phase_done)
          next_state = addr16_r ? i2c_pkg::st_reg_hi : i2c_pkg::st_reg_lo;
      i2c_pkg::st_reg_hi:
        if (phase_done)
          next_state = i2c_pkg::st_reg_lo;
      i2c_pkg::st_reg_lo:
        if (phase_done)
          next_state = rd_r ? i2c_pkg::st_restart_addr : i2c_pkg::st_write_data;
      i2c_pkg::st_write_data:
        if (phase_done)
          next_state = i2c_pkg::st_stop;
      i2c_pkg::st_restart_addr:
        if (phase_done)
          next_state = i2c_pkg::st_read_data;
      i2c_pkg::st_read_data:
        if (phase_done)
          next_state = i2c_pkg::st_stop;
      i2c_pkg::st_stop:
        if (phase_done)
          next_state = i2c_pkg::st_idle;
      default:
        next_state = i2c_pkg::st_idle;
    endcase
  end

  always_ff @(posedge i2c_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= i2c_pkg::st_idle;
      addr16_r <= 1'b0;
      rd_r     <= 1'b0;
      i2c_done <= 1'b0;
    end
    else
    begin
      state    <= next_state;
      i2c_done <= (state == i2c_pkg::st_stop) && phase_done;
      if (start_req)
      begin
        addr16_r <= addr16;
        rd_r     <= rd_wr_n;
      end
    end
  end

  // request payload
  always_ff @(posedge i2c_clk)
  begin
    if (start_req)
    begin
      dev_addr_r <= dev_addr;
      reg_addr_r <= reg_addr;
      wr_data_r  <= wr_data;
    end
  end

  always_comb
  begin
    case (state)
      i2c_pkg::st_dev_addr:     tx_byte = {dev_addr_r, 1'b0};
      i2c_pkg::st_restart_addr: tx_byte = {dev_addr_r, 1'b1};
      i2c_pkg::st_reg_hi:       tx_byte = reg_addr_r[`I2C_REG_ADDR_W-1 -: `I2C_BYTE_W];
      i2c_pkg::st_reg_lo:       tx_byte = reg_addr_r[`I2C_BYTE_W-1:0];
      i2c_pkg::st_write_data:   tx_byte = wr_data_r;
      default:                  tx_byte = '0;
    endcase
  end

endmodule

//--- i2c_bit_engine.sv
`include "i2c_macros.svh"

module i2c_bit_engine
(
  input  logic                i2c_clk,
  input  logic                rst_n,
  input  i2c_pkg::i2c_state_t state,
  input  i2c_pkg::byte_t      tx_byte,
  input  logic                sda_in,
  output logic                phase_done,
  output logic                scl,
  output logic                sda_out,
  output logic                sda_oe,
  output logic                i2c_ack,
  output i2c_pkg::byte_t      rd_data
);

  localparam int BIT_IDX_W = $clog2(`I2C_BYTE_W);

  localparam i2c_pkg::phase_cnt_t BIT_CYC = i2c_pkg::phase_cnt_t'(`I2C_BIT_CYCLES);
  localparam i2c_pkg::phase_cnt_t SLOT_RISE = i2c_pkg::phase_cnt_t'(1);
  localparam i2c_pkg::phase_cnt_t SLOT_FALL = BIT_CYC - SLOT_RISE;
  localparam i2c_pkg::phase_cnt_t ACK_REL =
    i2c_pkg::phase_cnt_t'(`I2C_BYTE_W * `I2C_BIT_CYCLES);
  localparam i2c_pkg::phase_cnt_t DEV_OFS =
    i2c_pkg::phase_cnt_t'(`I2C_DEV_PHASE_LEN - `I2C_BYTE_PHASE_LEN);
  localparam i2c_pkg::phase_cnt_t RESTART_OFS =
    i2c_pkg::phase_cnt_t'(`I2C_RESTART_PHASE_LEN - `I2C_BYTE_PHASE_LEN);

  i2c_pkg::phase_cnt_t  cnt;
  i2c_pkg::phase_cnt_t  last_cnt;
  i2c_pkg::phase_cnt_t  bit_ofs;
  i2c_pkg::phase_cnt_t  rel;
  i2c_pkg::phase_cnt_t  slot;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic                 in_prologue;
  logic                 is_read;
  logic                 sample_bit;
  logic                 last_ack;
  i2c_pkg::byte_t       rx_shift;

  // phase length and where the byte starts inside it
  always_comb
  begin
    last_cnt = i2c_pkg::phase_cnt_t'(`I2C_BYTE_PHASE_LEN - 1);
    bit_ofs  = '0;
    case (state)
      i2c_pkg::st_dev_addr:
      begin
        last_cnt = i2c_pkg::phase_cnt_t'(`I2C_DEV_PHASE_LEN - 1);
        bit_ofs  = DEV_OFS;
      end
      i2c_pkg::st_restart_addr:
      begin
        last_cnt = i2c_pkg::phase_cnt_t'(`I2C_RESTART_PHASE_LEN - 1);
        bit_ofs  = RESTART_OFS;
      end
      i2c_pkg::st_stop:
        last_cnt = i2c_pkg::phase_cnt_t'(`I2C_STOP_PHASE_LEN - 1);
      default:
        last_cnt = i2c_pkg::phase_cnt_t'(`I2C_BYTE_PHASE_LEN - 1);
    endcase
  end

  assign phase_done  = (state != i2c_pkg::st_idle) && (cnt == last_cnt);
  assign in_prologue = cnt < bit_ofs;
  assign rel         = cnt - bit_ofs;
  assign slot        = rel % BIT_CYC;
  assign bit_idx     = BIT_IDX_W'(rel / BIT_CYC);
  assign is_read     = state == i2c_pkg::st_read_data;
  assign sample_bit  = is_read && (rel < ACK_REL) && (slot == SLOT_RISE);

  always_ff @(posedge i2c_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt      <= '0;
      scl      <= 1'b1;
      sda_out  <= 1'b1;
      sda_oe   <= 1'b0;
      i2c_ack  <= 1'b0;
      last_ack <= 1'b0;
    end
    else
    begin
      i2c_ack <= 1'b0;
      if (state == i2c_pkg::st_idle || phase_done)
        cnt <= '0;
      else
        cnt <= cnt + SLOT_RISE;

      case (state)
        i2c_pkg::st_idle:
        begin
          scl     <= 1'b1;
          sda_out <= 1'b1;
          sda_oe  <= 1'b0;
        end
        i2c_pkg::st_stop:
        begin
          // sda rises while scl is high
          case (cnt)
            0:
            begin
              sda_oe  <= 1'b1;
              sda_out <= 1'b0;
            end
            1:
              scl <= 1'b1;
            3:
            begin
              sda_oe  <= 1'b0;
              sda_out <= 1'b1;
            end
            default:
              ;
          endcase
        end
        default:
        begin
          if (in_prologue && state == i2c_pkg::st_dev_addr)
          begin
            // start, sda falls under a high scl
            if (cnt == SLOT_RISE)
            begin
              sda_oe  <= 1'b1;
              sda_out <= 1'b0;
            end
            else if (cnt == DEV_OFS - SLOT_RISE)
              scl <= 1'b0;
          end
          else if (in_prologue)
          begin
            // repeated start
            if (cnt == '0)
            begin
              sda_oe  <= 1'b1;
              sda_out <= 1'b1;
            end
            else if (cnt == i2c_pkg::phase_cnt_t'(2))
              scl <= 1'b1;
            else if (cnt == RESTART_OFS - i2c_pkg::phase_cnt_t'(2))
              sda_out <= 1'b0;
            else if (cnt == RESTART_OFS - SLOT_RISE)
              scl <= 1'b0;
          end
          else if (rel < ACK_REL)
          begin
            if (slot == '0)
            begin
              sda_oe  <= !is_read;
              sda_out <= tx_byte[`I2C_BYTE_W - 1 - bit_idx];
            end
            else if (slot == SLOT_RISE)
              scl <= 1'b1;
            else if (slot == SLOT_FALL)
              scl <= 1'b0;
          end
          else if (rel == ACK_REL)
          begin
            // nack after the read byte, otherwise leave sda to the target
            sda_oe  <= is_read;
            sda_out <= 1'b1;
          end
          else if (rel == ACK_REL + SLOT_RISE)
            scl <= 1'b1;
          else if (rel == ACK_REL + i2c_pkg::phase_cnt_t'(2))
          begin
            if (is_read)
              // read byte counts when the target acked its read address
              i2c_ack <= last_ack;
            else
            begin
              i2c_ack  <= !sda_in;
              last_ack <= !sda_in;
            end
          end
          else
            scl <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge i2c_clk)
  begin
    if (sample_bit)
      rx_shift <= {rx_shift[`I2C_BYTE_W-2:0], sda_in};
    if (is_read && phase_done)
      rd_data <= rx_shift;
  end

endmodule

//--- i2c_master.sv
module i2c_master
(
  input  logic               i2c_clk,
  input  logic               rst_n,
  input  logic               i2c_exec,
  input  logic               addr16,
  input  logic               rd_wr_n,
  input  i2c_pkg::dev_addr_t dev_addr,
  input  i2c_pkg::reg_addr_t reg_addr,
  input  i2c_pkg::byte_t     wr_data,
  input  logic               sda_in,
  output logic               scl,
  output logic               sda_out,
  output logic               sda_oe,
  output logic               i2c_done,
  output logic               i2c_ack,
  output i2c_pkg::byte_t     rd_data
);

  i2c_pkg::i2c_state_t state;
  i2c_pkg::byte_t      tx_byte;
  logic                phase_done;

  i2c_txn_seq u_txn_seq
  (
    .i2c_clk    (i2c_clk),
    .rst_n      (rst_n),
    .i2c_exec   (i2c_exec),
    .addr16     (addr16),
    .rd_wr_n    (rd_wr_n),
    .phase_done (phase_done),
    .dev_addr   (dev_addr),
    .reg_addr   (reg_addr),
    .wr_data    (wr_data),
    .state      (state),
    .tx_byte    (tx_byte),
    .i2c_done   (i2c_done)
  );

  // sda pad lives outside, open drain
  i2c_bit_engine u_bit_engine
  (
    .i2c_clk    (i2c_clk),
    .rst_n      (rst_n),
    .state      (state),
    .tx_byte    (tx_byte),
    .sda_in     (sda_in),
    .phase_done (phase_done),
    .scl        (scl),
    .sda_out    (sda_out),
    .sda_oe     (sda_oe),
    .i2c_ack    (i2c_ack),
    .rd_data    (rd_data)
  );

endmodule

//--- i2c_slave_model.sv
module i2c_slave_model
#(
  parameter logic [6:0] DEV_ADDR = 7'h50
)
(
  input  logic scl,
  input  logic sda,
  output logic sda_low
);

  logic [7:0]  mem [0:65535];
  logic [7:0]  rx_q [$];
  logic [7:0]  shift;
  logic [7:0]  tx_data;
  logic [15:0] ptr;
  logic        scl_q;
  logic        sda_q;
  logic        active;
  logic        addr_done;
  logic        going_tx;
  logic        tx;
  int          bit_cnt;

  initial
  begin
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'(a >> 8) ^ 8'(a * 3) ^ 8'h5a;
    sda_low   = 1'b0;
    scl_q     = 1'b1;
    sda_q     = 1'b1;
    active    = 1'b0;
    addr_done = 1'b0;
    going_tx  = 1'b0;
    tx        = 1'b0;
    bit_cnt   = 0;
    ptr       = '0;
  end

  always @(posedge scl or negedge scl or posedge sda or negedge sda)
  begin
    if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b0 && sda_q === 1'b1)
    begin
      // repeated start takes the pointer from the bytes just written
      if (active && !going_tx && rx_q.size() > 0)
        ptr = (rx_q.size() == 1) ? {8'h00, rx_q[0]} : {rx_q[0], rx_q[1]};
      active    = 1'b1;
      addr_done = 1'b0;
      going_tx  = 1'b0;
      tx        = 1'b0;
      bit_cnt   = 0;
      sda_low   = 1'b0;
      rx_q.delete();
    end
    else if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b1 && sda_q === 1'b0)
    begin
      // stop commits a write, width known from the byte count
      if (!going_tx && rx_q.size() == 2)
        mem[{8'h00, rx_q[0]}] = rx_q[1];
      else if (!going_tx && rx_q.size() == 3)
        mem[{rx_q[0], rx_q[1]}] = rx_q[2];
      active  = 1'b0;
      tx      = 1'b0;
      sda_low = 1'b0;
    end
    else if (active && scl === 1'b1 && scl_q === 1'b0)
    begin
      if (bit_cnt < 8)
      begin
        shift   = {shift[6:0], sda};
        bit_cnt = bit_cnt + 1;
      end
      else
      begin
        bit_cnt = 0;
        // master nack ends the read
        if (tx && sda)
        begin
          tx     = 1'b0;
          active = 1'b0;
        end
      end
    end
    else if (active && scl === 1'b0 && scl_q === 1'b1)
    begin
      if (tx)
        sda_low = (bit_cnt < 8) ? !tx_data[7 - bit_cnt] : 1'b0;
      else if (bit_cnt == 8)
      begin
        if (!addr_done && shift[7:1] != DEV_ADDR)
          active = 1'b0;
        else
        begin
          if (!addr_done)
            going_tx = shift[0];
          else
            rx_q.push_back(shift);
          addr_done = 1'b1;
          sda_low   = 1'b1;
        end
      end
      else if (bit_cnt == 0 && sda_low)
      begin
        sda_low = 1'b0;
        if (going_tx)
        begin
          tx      = 1'b1;
          tx_data = mem[ptr];
          sda_low = !tx_data[7];
        end
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

//--- i2c_master_asserts.sv
module i2c_master_asserts
(
  input logic                i2c_clk,
  input logic                rst_n,
  input logic                scl,
  input logic                sda_oe,
  input logic                sda_in,
  input logic                i2c_done,
  input logic                i2c_ack,
  input i2c_pkg::i2c_state_t state
);

  a_done_pulse: assert property (@(posedge i2c_clk) disable iff (!rst_n)
    i2c_done |=> !i2c_done)
    else $error("i2c_done held for more than one cycle");

  a_reset_idle: assert property (@(posedge i2c_clk)
    $rose(rst_n) |-> (scl && !sda_oe))
    else $error("bus not released after reset");

  // sda may only move under a high scl for start, restart and stop
  a_sda_stable: assert property (@(posedge i2c_clk) disable iff (!rst_n)
    (scl && $past(scl) && sda_in != $past(sda_in)) |->
      (state == i2c_pkg::st_dev_addr || state == i2c_pkg::st_restart_addr ||
       state == i2c_pkg::st_stop))
    else $error("sda changed while scl high outside start or stop");

  a_idle_no_ack: assert property (@(posedge i2c_clk) disable iff (!rst_n)
    (state == i2c_pkg::st_idle) |-> !i2c_ack)
    else $error("i2c_ack pulsed while idle");

endmodule

bind i2c_master i2c_master_asserts u_asserts
(
  .i2c_clk  (i2c_clk),
  .rst_n    (rst_n),
  .scl      (scl),
  .sda_oe   (sda_oe),
  .sda_in   (sda_in),
  .i2c_done (i2c_done),
  .i2c_ack  (i2c_ack),
  .state    (state)
);

//--- tb_i2c_master.sv
`include "i2c_macros.svh"

module tb_i2c_master;

  localparam i2c_pkg::dev_addr_t SLAVE_ADDR = 7'h50;
  localparam int TXN_MAX_CYC = `I2C_DEV_PHASE_LEN + 2 * `I2C_BYTE_PHASE_LEN +
    `I2C_RESTART_PHASE_LEN + `I2C_BYTE_PHASE_LEN + `I2C_STOP_PHASE_LEN + 4;
  // 26 transactions plus one idle wait in the busy test
  localparam int NUM_TXN = 27;
  localparam int CLK_PERIOD = 4;
  localparam int RUN_LIMIT = 2 * CLK_PERIOD * (8 + NUM_TXN * TXN_MAX_CYC);

  logic               i2c_clk;
  logic               rst_n;
  logic               i2c_exec;
  logic               addr16;
  logic               rd_wr_n;
  i2c_pkg::dev_addr_t dev_addr;
  i2c_pkg::reg_addr_t reg_addr;
  i2c_pkg::byte_t     wr_data;
  logic               scl;
  logic               sda_out;
  logic               sda_oe;
  logic               i2c_done;
  logic               i2c_ack;
  i2c_pkg::byte_t     rd_data;
  logic               slave_low;
  logic               sda_line;

  int                 errors;
  int                 checks;
  int                 tests;
  int                 done_total;
  int                 done_target;
  int                 ack_cnt;
  int                 exp_acks;
  logic               exp_rd;
  i2c_pkg::byte_t     exp_data;
  i2c_pkg::byte_t     shadow [int];
  logic [31:0]        rng;

  // open-drain bus with pull-up
  assign sda_line = !((sda_oe && !sda_out) || slave_low);

  i2c_master dut
  (
    .i2c_clk  (i2c_clk),
    .rst_n    (rst_n),
    .i2c_exec (i2c_exec),
    .addr16   (addr16),
    .rd_wr_n  (rd_wr_n),
    .dev_addr (dev_addr),
    .reg_addr (reg_addr),
    .wr_data  (wr_data),
    .sda_in   (sda_line),
    .scl      (scl),
    .sda_out  (sda_out),
    .sda_oe   (sda_oe),
    .i2c_done (i2c_done),
    .i2c_ack  (i2c_ack),
    .rd_data  (rd_data)
  );

  i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) u_slave
  (
    .scl     (scl),
    .sda     (sda_line),
    .sda_low (slave_low)
  );

  initial
  begin
    i2c_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i2c_clk = ~i2c_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // power-up contents of the target memory
  function automatic i2c_pkg::byte_t fill_byte(input int idx);
    return 8'(idx >> 8) ^ 8'(idx * 3) ^ 8'h5a;
  endfunction

  function automatic i2c_pkg::byte_t expect_txn(input logic rd, input logic a16,
    input i2c_pkg::dev_addr_t dev, input i2c_pkg::reg_addr_t ra,
    input i2c_pkg::byte_t wd, output int acks);
    int idx;
    idx = a16 ? int'(ra) : int'(ra[7:0]);
    if (dev != SLAVE_ADDR)
    begin
      acks = 0;
      return 8'hff;
    end
    acks = (rd ? 4 : 3) + (a16 ? 1 : 0);
    if (!rd)
    begin
      shadow[idx] = wd;
      return wd;
    end
    return shadow.exists(idx) ? shadow[idx] : fill_byte(idx);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got,
    input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic start_txn(input logic rd, input logic a16, input i2c_pkg::dev_addr_t dev,
    input i2c_pkg::reg_addr_t ra, input i2c_pkg::byte_t wd);
    exp_rd      = rd;
    exp_data    = expect_txn(rd, a16, dev, ra, wd, exp_acks);
    done_target = done_total + 1;
    @(posedge i2c_clk);
    i2c_exec <= 1'b1;
    rd_wr_n  <= rd;
    addr16   <= a16;
    dev_addr <= dev;
    reg_addr <= ra;
    wr_data  <= wd;
    @(posedge i2c_clk);
    i2c_exec <= 1'b0;
  endtask

  task automatic run_txn(input logic rd, input logic a16, input i2c_pkg::dev_addr_t dev,
    input i2c_pkg::reg_addr_t ra, input i2c_pkg::byte_t wd);
    start_txn(rd, a16, dev, ra, wd);
    wait (done_total == done_target);
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests++;
    $display("test %s: %s", name, (errors == err_mark) ? "ok" : "errors");
  endtask

  // ack pulses per transaction, checked when done pulses
  always @(posedge i2c_clk)
  begin
    if (i2c_ack === 1'b1)
      ack_cnt++;
    if (i2c_done === 1'b1)
    begin
      check_eq("ack pulses", ack_cnt, exp_acks);
      if (exp_rd)
        check_eq("rd_data", 32'(rd_data), 32'(exp_data));
      ack_cnt = 0;
      done_total++;
    end
  end

  initial
  begin
    int                 err_mark;
    logic               rd;
    logic               a16;
    i2c_pkg::reg_addr_t ra;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    done_total  = 0;
    done_target = 0;
    ack_cnt     = 0;
    exp_acks    = 0;
    exp_rd      = 1'b0;
    exp_data    = '0;
    rng         = 32'd26;
    rst_n       <= 1'b0;
    i2c_exec    <= 1'b0;
    addr16      <= 1'b0;
    rd_wr_n     <= 1'b0;
    dev_addr    <= '0;
    reg_addr    <= '0;
    wr_data     <= '0;
    repeat (8) @(posedge i2c_clk);
    rst_n <= 1'b1;
    @(posedge i2c_clk);

    err_mark = errors;
    check_eq("scl after reset", 32'(scl), 1);
    check_eq("sda_oe after reset", 32'(sda_oe), 0);
    report_test("reset_idle", err_mark);

    err_mark = errors;
    run_txn(1'b0, 1'b0, SLAVE_ADDR, 16'h0012, 8'h3c);
    check_eq("slave memory", 32'(u_slave.mem[16'h0012]), 32'h3c);
    report_test("write_8bit", err_mark);

    err_mark = errors;
    run_txn(1'b0, 1'b1, SLAVE_ADDR, 16'h1234, 8'ha7);
    run_txn(1'b1, 1'b1, SLAVE_ADDR, 16'h1234, 8'h00);
    report_test("write_read_16bit", err_mark);

    err_mark = errors;
    for (int i = 0; i < 20; i++)
    begin
      rng = xorshift(rng);
      rd  = rng[0];
      a16 = rng[1];
      // narrow address range so reads hit earlier writes
      ra  = a16 ? {7'h00, rng[16], 4'h0, rng[7:4]} : {12'h000, rng[7:4]};
      run_txn(rd, a16, SLAVE_ADDR, ra, rng[31:24]);
    end
    report_test("random_mix", err_mark);

    err_mark = errors;
    run_txn(1'b0, 1'b0, 7'h23, 16'h0040, 8'h99);
    run_txn(1'b1, 1'b1, 7'h23, 16'h0040, 8'h00);
    report_test("wrong_device", err_mark);

    err_mark = errors;
    start_txn(1'b0, 1'b0, SLAVE_ADDR, 16'h0077, 8'h61);
    repeat (10) @(posedge i2c_clk);
    i2c_exec <= 1'b1;
    @(posedge i2c_clk);
    i2c_exec <= 1'b0;
    wait (done_total == done_target);
    repeat (TXN_MAX_CYC) @(posedge i2c_clk);
    check_eq("done count", done_total, done_target);
    report_test("exec_while_busy", err_mark);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    #(RUN_LIMIT);
    $display("timeout: transactions did not complete within %0d time units", RUN_LIMIT);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
i2c_pkg.sv
i2c_txn_seq.sv
i2c_bit_engine.sv
i2c_master.sv
i2c_slave_model.sv
i2c_master_asserts.sv
tb_i2c_master.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tb_i2c_master -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
